// File: rtl/link_pkg.sv
package link_pkg;

    // ==========================================================
    // frame sync bytes
    // ==========================================================
    localparam logic [7:0] rx_header_h = 8'hAA;
    localparam logic [7:0] rx_header_l = 8'h55;
    localparam logic [7:0] tx_header_h = 8'hAA;
    localparam logic [7:0] tx_header_l = 8'h44;

    // command codes seen on the command bus
    localparam logic [7:0] cmd_set_pins = 8'h10;
    localparam logic [7:0] cmd_set_dac  = 8'h20;
    localparam logic [7:0] cmd_echo     = 8'h30;

    // source code carried in upload frames
    localparam logic [7:0] src_echo = 8'h30;

    // ==========================================================
    // buffer sizes
    // ==========================================================
    localparam int max_payload    = 64;
    localparam int payload_addr_w = 6;
    localparam int echo_depth     = 16;

    typedef logic [15:0]               len_t;
    typedef logic [payload_addr_w-1:0] payload_addr_t;

endpackage

// File: rtl/dac_pkg.sv
package dac_pkg;

    localparam int dac_w = 14;

    // 6554 / 8192, roughly 0.8
    localparam logic [dac_w-1:0] dac_scale = 14'd6554;

    // offset binary mid-scale
    localparam logic [dac_w-1:0] dac_zero = 14'h2000;

    typedef logic [dac_w-1:0] dac_sample_t;

endpackage

// File: rtl/frame_parser.sv
`timescale 1ns/1ps

module frame_parser (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              usb_data,
    input  logic                    usb_data_valid,
    input  logic                    frame_release,
    input  link_pkg::payload_addr_t payload_addr,
    output logic [7:0]              payload_data,
    output logic                    parse_done,
    output logic [7:0]              frame_cmd,
    output link_pkg::len_t          frame_len
);
    import link_pkg::*;

    typedef enum logic [2:0] {
        ST_HDR_H,
        ST_HDR_L,
        ST_CMD,
        ST_LEN_H,
        ST_LEN_L,
        ST_PAYLOAD,
        ST_CSUM,
        ST_HOLD
    } state_t;

    state_t     state;
    logic       valid_d;
    logic       strobe;
    len_t       rx_len;
    len_t       byte_cnt;
    logic [7:0] sum;
    logic [7:0] payload_mem [max_payload];

    // one strobe per rising edge of the host valid
    assign strobe = usb_data_valid & ~valid_d;
    assign rx_len = {frame_len[15:8], usb_data};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d    <= 1'b0;
            state      <= ST_HDR_H;
            parse_done <= 1'b0;
            byte_cnt   <= '0;
            sum        <= '0;
            frame_cmd  <= '0;
            frame_len  <= '0;
        end else begin
            valid_d    <= usb_data_valid;
            parse_done <= 1'b0;
            if (state == ST_HOLD) begin
                // bytes arriving here are dropped
                if (frame_release) begin
                    state <= ST_HDR_H;
                end
            end else if (strobe) begin
                case (state)
                    ST_HDR_H: begin
                        if (usb_data == rx_header_h) begin
                            state <= ST_HDR_L;
                        end
                    end
                    ST_HDR_L: begin
                        if (usb_data == rx_header_l) begin
                            state <= ST_CMD;
                        end else if (usb_data != rx_header_h) begin
                            state <= ST_HDR_H;
                        end
                    end
                    ST_CMD: begin
                        frame_cmd <= usb_data;
                        sum       <= usb_data;
                        state     <= ST_LEN_H;
                    end
                    ST_LEN_H: begin
                        frame_len[15:8] <= usb_data;
                        sum             <= sum + usb_data;
                        state           <= ST_LEN_L;
                    end
                    ST_LEN_L: begin
                        frame_len[7:0] <= usb_data;
                        sum            <= sum + usb_data;
                        byte_cnt       <= '0;
                        // oversize frame, back to hunting
                        if (rx_len > len_t'(max_payload)) begin
                            state <= ST_HDR_H;
                        end else if (rx_len == '0) begin
                            state <= ST_CSUM;
                        end else begin
                            state <= ST_PAYLOAD;
                        end
                    end
                    ST_PAYLOAD: begin
                        sum      <= sum + usb_data;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt + 1'b1 == frame_len) begin
                            state <= ST_CSUM;
                        end
                    end
                    ST_CSUM: begin
                        if (usb_data == sum) begin
                            parse_done <= 1'b1;
                            state      <= ST_HOLD;
                        end else begin
                            state <= ST_HDR_H;
                        end
                    end
                    default: state <= ST_HDR_H;
                endcase
            end
        end
    end

    // payload buffer, registered read port
    always_ff @(posedge clk) begin
        if (strobe && state == ST_PAYLOAD) begin
            payload_mem[byte_cnt[payload_addr_w-1:0]] <= usb_data;
        end
        payload_data <= payload_mem[payload_addr];
    end

endmodule

// File: rtl/command_dispatcher.sv
`timescale 1ns/1ps

module command_dispatcher (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    parse_done,
    input  logic [7:0]              frame_cmd,
    input  link_pkg::len_t          frame_len,
    output link_pkg::payload_addr_t payload_addr,
    input  logic [7:0]              payload_data,
    output logic                    frame_release,
    input  logic                    cmd_ready,
    output logic [7:0]              cmd_type,
    output link_pkg::len_t          cmd_length,
    output logic [7:0]              cmd_data,
    output link_pkg::len_t          cmd_data_index,
    output logic                    cmd_start,
    output logic                    cmd_data_valid,
    output logic                    cmd_done,
    output logic                    led_out
);
    import link_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RUN} state_t;

    state_t state;
    logic   launch;
    logic   rd_issue;
    logic   rd_end;
    logic   rd_issue_d;
    logic   end_d;
    len_t   rd_idx;
    len_t   rd_idx_d;

    assign launch        = (parse_done || state == ST_WAIT) && cmd_ready;
    assign rd_issue      = (state == ST_RUN) && (rd_idx != cmd_length);
    assign rd_end        = (state == ST_RUN) && (rd_idx == cmd_length);
    assign payload_addr  = rd_idx[payload_addr_w-1:0];
    // parser is freed as the command completes
    assign frame_release = cmd_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            rd_idx         <= '0;
            rd_idx_d       <= '0;
            rd_issue_d     <= 1'b0;
            end_d          <= 1'b0;
            cmd_start      <= 1'b0;
            cmd_data_valid <= 1'b0;
            cmd_done       <= 1'b0;
            led_out        <= 1'b0;
            cmd_type       <= '0;
            cmd_length     <= '0;
            cmd_data       <= '0;
            cmd_data_index <= '0;
        end else begin
            cmd_start <= 1'b0;
            // ==========================================================
            // read latency pipeline, beat two cycles after the address
            // ==========================================================
            rd_issue_d     <= rd_issue;
            rd_idx_d       <= rd_idx;
            end_d          <= rd_end;
            cmd_data_valid <= rd_issue_d;
            cmd_done       <= end_d;
            if (rd_issue_d) begin
                cmd_data       <= payload_data;
                cmd_data_index <= rd_idx_d;
            end
            case (state)
                ST_RUN: begin
                    if (rd_issue) begin
                        rd_idx <= rd_idx + 1'b1;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    if (launch) begin
                        state      <= ST_RUN;
                        cmd_start  <= 1'b1;
                        cmd_type   <= frame_cmd;
                        cmd_length <= frame_len;
                        rd_idx     <= '0;
                        led_out    <= ~led_out;
                    end else if (parse_done) begin
                        // handler busy, hold the frame
                        state <= ST_WAIT;
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/output_level_handler.sv
`timescale 1ns/1ps

module output_level_handler (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [7:0]           cmd_type,
    input  link_pkg::len_t       cmd_length,
    input  logic [7:0]           cmd_data,
    input  link_pkg::len_t       cmd_data_index,
    input  logic                 cmd_start,
    input  logic                 cmd_data_valid,
    input  logic                 cmd_done,
    output logic [7:0]           pins,
    output dac_pkg::dac_sample_t dac_data_a,
    output dac_pkg::dac_sample_t dac_data_b
);
    import link_pkg::*;
    import dac_pkg::*;

    logic       pin_cmd;
    logic       dac_cmd;
    logic [7:0] dac_bytes [4];

    // 14-bit signed sample, scaled to 0.8, sign bit flipped
    function automatic dac_sample_t to_offset_binary(input logic [7:0] hi, input logic [7:0] lo);
        logic signed [dac_w-1:0]   sample;
        logic signed [2*dac_w-1:0] product;
        sample  = {hi[5:0], lo};
        product = sample * $signed(dac_scale);
        return {~product[2*dac_w-2], product[2*dac_w-3:dac_w-1]};
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pin_cmd    <= 1'b0;
            dac_cmd    <= 1'b0;
            pins       <= '0;
            dac_data_a <= dac_zero;
            dac_data_b <= dac_zero;
        end else begin
            if (cmd_start) begin
                pin_cmd <= (cmd_type == cmd_set_pins);
                dac_cmd <= (cmd_type == cmd_set_dac) && (cmd_length == 16'd4);
            end
            if (pin_cmd && cmd_data_valid && cmd_data_index == '0) begin
                pins <= cmd_data;
            end
            if (dac_cmd && cmd_done) begin
                dac_data_a <= to_offset_binary(dac_bytes[0], dac_bytes[1]);
                dac_data_b <= to_offset_binary(dac_bytes[2], dac_bytes[3]);
            end
        end
    end

    // a_hi, a_lo, b_hi, b_lo
    always_ff @(posedge clk) begin
        if (dac_cmd && cmd_data_valid) begin
            dac_bytes[cmd_data_index[1:0]] <= cmd_data;
        end
    end

endmodule

// File: rtl/echo_handler.sv
`timescale 1ns/1ps

module echo_handler (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [7:0]     cmd_type,
    input  link_pkg::len_t cmd_length,
    input  logic [7:0]     cmd_data,
    input  link_pkg::len_t cmd_data_index,
    input  logic           cmd_start,
    input  logic           cmd_data_valid,
    input  logic           cmd_done,
    output logic           cmd_ready,
    output logic           upload_req,
    output logic [7:0]     upload_source,
    output link_pkg::len_t upload_len,
    output logic [7:0]     upload_data,
    output logic           upload_valid,
    input  logic           upload_ready
);
    import link_pkg::*;

    logic       busy;
    logic       echo_start;
    len_t       rd_ptr;
    logic [7:0] echo_mem [echo_depth];

    assign echo_start    = cmd_start && (cmd_type == cmd_echo);
    // drops in the same cycle as the echo start
    assign cmd_ready     = ~busy & ~echo_start;
    assign upload_source = src_echo;
    assign upload_valid  = upload_req;
    assign upload_data   = echo_mem[rd_ptr[$clog2(echo_depth)-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            upload_req <= 1'b0;
            upload_len <= '0;
            rd_ptr     <= '0;
        end else begin
            if (echo_start) begin
                busy       <= 1'b1;
                rd_ptr     <= '0;
                upload_len <= (cmd_length > len_t'(echo_depth)) ? len_t'(echo_depth) : cmd_length;
            end
            if (busy && cmd_done) begin
                // empty echo has nothing to send
                if (upload_len == '0) begin
                    busy <= 1'b0;
                end else begin
                    upload_req <= 1'b1;
                end
            end
            if (upload_valid && upload_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (rd_ptr + 1'b1 == upload_len) begin
                    upload_req <= 1'b0;
                    busy       <= 1'b0;
                end
            end
        end
    end

    // bytes past the buffer depth are ignored
    always_ff @(posedge clk) begin
        if (busy && cmd_data_valid && cmd_data_index < len_t'(echo_depth)) begin
            echo_mem[cmd_data_index[$clog2(echo_depth)-1:0]] <= cmd_data;
        end
    end

endmodule

// File: rtl/upload_framer.sv
`timescale 1ns/1ps

module upload_framer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           upload_req,
    input  logic [7:0]     upload_source,
    input  link_pkg::len_t upload_len,
    input  logic [7:0]     upload_data,
    input  logic           upload_valid,
    output logic           upload_ready,
    output logic [7:0]     usb_upload_data,
    output logic           usb_upload_valid,
    input  logic           usb_upload_ready
);
    import link_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HDR_L,
        ST_SRC,
        ST_LEN_H,
        ST_LEN_L,
        ST_DATA,
        ST_CSUM
    } state_t;

    state_t     state;
    logic       load;
    len_t       len_q;
    len_t       data_cnt;
    logic [7:0] sum;

    // output register is empty or its byte leaves this cycle
    assign load         = ~usb_upload_valid | usb_upload_ready;
    assign upload_ready = (state == ST_DATA) && load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= ST_IDLE;
            usb_upload_valid <= 1'b0;
            usb_upload_data  <= '0;
            len_q            <= '0;
            data_cnt         <= '0;
            sum              <= '0;
        end else if (load) begin
            usb_upload_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (upload_req) begin
                        usb_upload_data  <= tx_header_h;
                        usb_upload_valid <= 1'b1;
                        len_q            <= upload_len;
                        state            <= ST_HDR_L;
                    end
                end
                ST_HDR_L: begin
                    usb_upload_data  <= tx_header_l;
                    usb_upload_valid <= 1'b1;
                    state            <= ST_SRC;
                end
                ST_SRC: begin
                    usb_upload_data  <= upload_source;
                    usb_upload_valid <= 1'b1;
                    sum              <= upload_source;
                    state            <= ST_LEN_H;
                end
                ST_LEN_H: begin
                    usb_upload_data  <= len_q[15:8];
                    usb_upload_valid <= 1'b1;
                    sum              <= sum + len_q[15:8];
                    state            <= ST_LEN_L;
                end
                ST_LEN_L: begin
                    usb_upload_data  <= len_q[7:0];
                    usb_upload_valid <= 1'b1;
                    sum              <= sum + len_q[7:0];
                    data_cnt         <= '0;
                    state            <= (len_q == '0) ? ST_CSUM : ST_DATA;
                end
                ST_DATA: begin
                    if (upload_valid) begin
                        usb_upload_data  <= upload_data;
                        usb_upload_valid <= 1'b1;
                        sum              <= sum + upload_data;
                        data_cnt         <= data_cnt + 1'b1;
                        if (data_cnt + 1'b1 == len_q) begin
                            state <= ST_CSUM;
                        end
                    end
                end
                ST_CSUM: begin
                    usb_upload_data  <= sum;
                    usb_upload_valid <= 1'b1;
                    state            <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/usb_command_bridge.sv
`timescale 1ns/1ps

module usb_command_bridge (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [7:0]           usb_data,
    input  logic                 usb_data_valid,
    output logic                 led_out,
    output logic [7:0]           pins,
    output dac_pkg::dac_sample_t dac_data_a,
    output dac_pkg::dac_sample_t dac_data_b,
    output logic [7:0]           usb_upload_data,
    output logic                 usb_upload_valid,
    input  logic                 usb_upload_ready
);
    import link_pkg::*;

    // ==========================================================
    // parser to dispatcher
    // ==========================================================
    payload_addr_t payload_addr;
    logic [7:0]    payload_data;
    logic          parse_done;
    logic [7:0]    frame_cmd;
    len_t          frame_len;
    logic          frame_release;

    // command bus
    logic [7:0] cmd_type;
    len_t       cmd_length;
    logic [7:0] cmd_data;
    len_t       cmd_data_index;
    logic       cmd_start;
    logic       cmd_data_valid;
    logic       cmd_done;
    logic       cmd_ready;

    // echo handler to framer
    logic       upload_req;
    logic [7:0] upload_source;
    len_t       upload_len;
    logic [7:0] upload_data;
    logic       upload_valid;
    logic       upload_ready;

    // port names match the wires above
    frame_parser u_parser (.*);

    command_dispatcher u_dispatcher (.*);

    output_level_handler u_levels (.*);

    echo_handler u_echo (.*);

    upload_framer u_framer (.*);

endmodule

// File: bench/bridge_checker.sv
`timescale 1ns/1ps

module bridge_checker (
    input logic       clk,
    input logic       rst_n,
    input logic [7:0] usb_upload_data,
    input logic       usb_upload_valid,
    input logic       usb_upload_ready,
    input logic       cmd_start,
    input logic       cmd_data_valid,
    input logic       parse_done,
    input logic       frame_release
);
    // high from parse_done until the parser is freed
    logic frame_held;
    // number of failed assertions so far
    int   failures = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_held <= 1'b0;
        end else if (parse_done) begin
            frame_held <= 1'b1;
        end else if (frame_release) begin
            frame_held <= 1'b0;
        end
    end

    upload_hold: assert property (@(posedge clk) disable iff (!rst_n)
        usb_upload_valid && !usb_upload_ready |=> usb_upload_valid && $stable(usb_upload_data))
        else begin
            failures = failures + 1;
            $error("upload byte changed while the host held ready low");
        end

    start_vs_beat: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd_start && cmd_data_valid))
        else begin
            failures = failures + 1;
            $error("cmd_start and cmd_data_valid high together");
        end

    single_frame: assert property (@(posedge clk) disable iff (!rst_n)
        parse_done |-> !frame_held)
        else begin
            failures = failures + 1;
            $error("second parse_done before frame_release");
        end

endmodule

bind usb_command_bridge bridge_checker u_checker (
    .clk              (clk),
    .rst_n            (rst_n),
    .usb_upload_data  (usb_upload_data),
    .usb_upload_valid (usb_upload_valid),
    .usb_upload_ready (usb_upload_ready),
    .cmd_start        (cmd_start),
    .cmd_data_valid   (cmd_data_valid),
    .parse_done       (parse_done),
    .frame_release    (frame_release)
);

// File: bench/tb_usb_command_bridge.sv
`timescale 1ns/1ps

module tb_usb_command_bridge;
    import link_pkg::*;
    import dac_pkg::*;

    // roughly three times the length of the whole sequence
    localparam int max_cycles = 6000;

    logic        clk;
    logic        rst_n;
    logic [7:0]  usb_data;
    logic        usb_data_valid;
    logic        led_out;
    logic [7:0]  pins;
    dac_sample_t dac_data_a;
    dac_sample_t dac_data_b;
    logic [7:0]  usb_upload_data;
    logic        usb_upload_valid;
    logic        usb_upload_ready;

    integer      seed;
    int          cycle_count;
    int          n;
    logic [7:0]  payload [80];
    logic [7:0]  expected_q [$];
    logic        led_expected;
    logic [7:0]  pins_expected;
    dac_sample_t dac_a_expected;
    dac_sample_t dac_b_expected;

    usb_command_bridge i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    // random host back-pressure
    always @(negedge clk) begin
        if (rst_n) begin
            usb_upload_ready = (($random(seed) & 3) != 0);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // ==========================================================
    // reference model
    // ==========================================================
    // signed 14-bit sample times 6554/8192, sign bit flipped
    function automatic dac_sample_t expected_dac_code(input logic [7:0] hi, input logic [7:0] lo);
        int sample;
        int product;
        sample = int'({hi[5:0], lo});
        if (sample >= 8192) begin
            sample = sample - 16384;
        end
        product = sample * 6554;
        return dac_sample_t'(product >>> 13) ^ 14'h2000;
    endfunction

    // echo returns at most 16 bytes
    function automatic void build_expected_frame(input int len);
        int         kept;
        int         i;
        logic [7:0] sum;
        kept = (len > 16) ? 16 : len;
        sum  = 8'h30 + 8'(kept >> 8) + 8'(kept);
        expected_q.push_back(8'hAA);
        expected_q.push_back(8'h44);
        expected_q.push_back(8'h30);
        expected_q.push_back(8'(kept >> 8));
        expected_q.push_back(8'(kept));
        for (i = 0; i < kept; i++) begin
            expected_q.push_back(payload[i]);
            sum = sum + payload[i];
        end
        expected_q.push_back(sum);
    endfunction

    // compare every upload byte as it is handed to the host
    always @(posedge clk) begin
        if (rst_n && usb_upload_valid && usb_upload_ready) begin
            if (expected_q.size() == 0) begin
                $display("Upload byte 0x%0h arrived when no upload frame was expected",
                         usb_upload_data);
                $display("Verification failed");
                $fatal(1, "unexpected upload");
            end else begin
                check_value(usb_upload_data, expected_q.pop_front(), "upload frame byte");
            end
        end
    end

    // ==========================================================
    // stimulus
    // ==========================================================
    task automatic send_byte(input logic [7:0] value);
        usb_data       = value;
        usb_data_valid = 1'b1;
        @(negedge clk);
        usb_data_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] cmd, input int len, input logic corrupt);
        logic [7:0] sum;
        int         i;
        sum = cmd + 8'(len >> 8) + 8'(len);
        send_byte(8'hAA);
        send_byte(8'h55);
        send_byte(cmd);
        send_byte(8'(len >> 8));
        send_byte(8'(len));
        for (i = 0; i < len; i++) begin
            send_byte(payload[i]);
            sum = sum + payload[i];
        end
        send_byte(corrupt ? ~sum : sum);
    endtask

    // one more cycle lets the DAC register settle
    task automatic wait_command_done();
        while (!i_dut.cmd_done) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic wait_bridge_idle();
        while (expected_q.size() != 0 || !i_dut.cmd_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic check_outputs(input string step);
        check_value(32'(led_out), 32'(led_expected), {step, ": led_out"});
        check_value(32'(pins), 32'(pins_expected), {step, ": pins"});
        check_value(32'(dac_data_a), 32'(dac_a_expected), {step, ": dac_data_a"});
        check_value(32'(dac_data_b), 32'(dac_b_expected), {step, ": dac_data_b"});
    endtask

    task automatic send_pins(input logic [7:0] pattern);
        payload[0] = pattern;
        payload[1] = ~pattern;
        send_frame(8'h10, 2, 1'b0);
        wait_command_done();
        pins_expected = pattern;
        led_expected  = ~led_expected;
        check_outputs("set pins");
    endtask

    task automatic send_dac(input logic [7:0] a_hi, input logic [7:0] a_lo,
                            input logic [7:0] b_hi, input logic [7:0] b_lo);
        payload[0] = a_hi;
        payload[1] = a_lo;
        payload[2] = b_hi;
        payload[3] = b_lo;
        send_frame(8'h20, 4, 1'b0);
        wait_command_done();
        dac_a_expected = expected_dac_code(a_hi, a_lo);
        dac_b_expected = expected_dac_code(b_hi, b_lo);
        led_expected   = ~led_expected;
        check_outputs("set DAC");
    endtask

    task automatic send_echo(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            payload[i] = 8'($random(seed));
        end
        build_expected_frame(len);
        send_frame(8'h30, len, 1'b0);
        wait_bridge_idle();
        led_expected = ~led_expected;
        check_outputs("echo");
    endtask

    initial begin
        seed             = 32'hd407_c4a2;
        cycle_count      = 0;
        rst_n            = 1'b0;
        usb_data         = '0;
        usb_data_valid   = 1'b0;
        usb_upload_ready = 1'b0;
        led_expected     = 1'b0;
        pins_expected    = '0;
        dac_a_expected   = 14'h2000;
        dac_b_expected   = 14'h2000;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_outputs("after reset");

        send_pins(8'h5A);

        // positive, negative, full scale, minus one, upper hi bits ignored
        send_dac(8'h0F, 8'hA0, 8'h30, 8'h10);
        send_dac(8'h1F, 8'hFF, 8'h20, 8'h00);
        send_dac(8'h3F, 8'hFF, 8'hC5, 8'h81);
        for (n = 0; n < 3; n++) begin
            send_dac(8'($random(seed)), 8'($random(seed)), 8'($random(seed)),
                     8'($random(seed)));
        end

        for (n = 0; n < 14; n++) begin
            send_echo(1 + ($random(seed) & 15));
        end
        send_echo(16);
        send_echo(20);

        // bad checksum, then an oversize frame of zeros
        payload[0] = 8'hFF;
        send_frame(8'h10, 1, 1'b1);
        check_outputs("after bad checksum");
        for (n = 0; n < 65; n++) begin
            payload[n] = 8'h00;
        end
        send_frame(8'h10, 65, 1'b0);
        check_outputs("after oversize frame");
        send_pins(8'h96);

        // unknown command only toggles the LED
        payload[0] = 8'h3C;
        payload[1] = 8'h00;
        send_frame(8'h77, 2, 1'b0);
        wait_command_done();
        wait_bridge_idle();
        led_expected = ~led_expected;
        check_outputs("unknown command");
        send_echo(3);

        if (i_dut.u_checker.failures != 0) begin
            $display("%0d protocol assertion failures were seen during the run",
                     i_dut.u_checker.failures);
            $display("Verification failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: build.f
rtl/link_pkg.sv
rtl/dac_pkg.sv
rtl/frame_parser.sv
rtl/command_dispatcher.sv
rtl/output_level_handler.sv
rtl/echo_handler.sv
rtl/upload_framer.sv
rtl/usb_command_bridge.sv
bench/bridge_checker.sv
bench/tb_usb_command_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_usb_command_bridge \
    -f build.f \
    -o sim_tb_usb_command_bridge

output=$(./obj_dir/sim_tb_usb_command_bridge 2>&1) || true
echo "$output"
if echo "$output" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi
